//--- cgmii_consts.svh
`ifndef CGMII_CONSTS_SVH
`define CGMII_CONSTS_SVH

// Word geometry
`define CGMII_DATA_W      64
`define CGMII_CTRL_W      8

// Generator configuration widths
`define CGMII_IDLE_NBIT   5
`define CGMII_DATA_NBIT   8
`define CGMII_ERR_WORDS   4     // Error words per forced burst

// Buffer sizing
`define CGMII_FIFO_DEPTH  16
`define CGMII_FIFO_AFULL  12    // Leaves room for the registered level lag

`define CGMII_CNT_W       16

// Control character of one byte lane
`define CGMII_IDLE_BYTE   8'h07
`define CGMII_START_BYTE  8'hFB
`define CGMII_TERM_BYTE   8'hFD
`define CGMII_ERR_BYTE    8'hFE

`endif

//--- cgmii_frame_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "cgmii_consts.svh"

module cgmii_frame_checker import cgmii_pkg::*; (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_rx_enable,
	input  logic        i_empty,
	input  cgmii_data_t i_rd_data,
	input  cgmii_ctrl_t i_rd_ctrl,
	output logic        o_rd_en,
	output logic        o_frame_strobe,
	output logic        o_frame_good,
	output data_count_t o_frame_len,
	output stat_count_t o_good_frames,
	output stat_count_t o_bad_frames,
	output stat_count_t o_error_words
);

	chk_state_t  state;
	logic        valid_q;       // FIFO read data is valid this cycle
	data_count_t len_q;
	logic [7:0]  exp_byte;
	logic        mismatch_q;
	cgmii_data_t exp_word;
	logic        is_idle;
	logic        is_start;
	logic        is_data;
	logic        is_term;
	logic        is_err;

	assign o_rd_en = i_rx_enable && !i_empty;

	always_comb begin
		for (int i = 0; i < `CGMII_CTRL_W; i++) begin
			exp_word[8*i +: 8] = exp_byte + 8'(i);
		end
	end

	// Word decode
	assign is_idle  = (i_rd_ctrl == '1) && (i_rd_data == {`CGMII_CTRL_W{`CGMII_IDLE_BYTE}});
	assign is_err   = (i_rd_ctrl == '1) && (i_rd_data == {`CGMII_CTRL_W{`CGMII_ERR_BYTE}});
	assign is_term  = (i_rd_ctrl == '1) &&
		(i_rd_data == {{(`CGMII_CTRL_W-1){`CGMII_IDLE_BYTE}}, `CGMII_TERM_BYTE});
	assign is_start = (i_rd_ctrl == cgmii_ctrl_t'(1)) &&
		(i_rd_data == cgmii_data_t'(`CGMII_START_BYTE));
	assign is_data  = (i_rd_ctrl == '0);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state          <= CHK_IDLE;
			valid_q        <= 1'b0;
			len_q          <= '0;
			exp_byte       <= '0;
			mismatch_q     <= 1'b0;
			o_frame_strobe <= 1'b0;
			o_frame_good   <= 1'b0;
			o_good_frames  <= '0;
			o_bad_frames   <= '0;
			o_error_words  <= '0;
		end else begin
			valid_q        <= o_rd_en;
			o_frame_strobe <= 1'b0;
			if (valid_q) begin
				case (state)
					CHK_IDLE: begin
						if (is_start) begin
							state      <= CHK_FRAME;
							len_q      <= '0;
							exp_byte   <= '0;
							mismatch_q <= 1'b0;
						end else if (is_err) begin
							o_error_words <= o_error_words + 1'b1;
						end else if (!is_idle) begin
							o_bad_frames <= o_bad_frames + 1'b1;  // Stray word outside a frame
						end
					end
					CHK_FRAME: begin
						if (is_data) begin
							len_q    <= len_q + 1'b1;
							exp_byte <= exp_byte + 8'd8;
							if (i_rd_data != exp_word) mismatch_q <= 1'b1;
						end else if (is_term) begin
							o_frame_strobe <= 1'b1;
							o_frame_good   <= !mismatch_q;
							state          <= CHK_IDLE;
							if (mismatch_q) o_bad_frames <= o_bad_frames + 1'b1;
							else            o_good_frames <= o_good_frames + 1'b1;
						end else begin
							// A new start word opens the next frame at once
							o_frame_strobe <= 1'b1;
							o_frame_good   <= 1'b0;
							o_bad_frames   <= o_bad_frames + 1'b1;
							len_q          <= '0;
							exp_byte       <= '0;
							mismatch_q     <= 1'b0;
							state          <= is_start ? CHK_FRAME : CHK_IDLE;
							if (is_err) o_error_words <= o_error_words + 1'b1;
						end
					end
					default: state <= CHK_IDLE;
				endcase
			end
		end
	end

	// Any non-data word inside a frame ends it
	always_ff @(posedge i_clock) begin
		if (valid_q && state == CHK_FRAME && !is_data) begin
			o_frame_len <= len_q;
		end
	end

endmodule

`default_nettype wire

//--- cgmii_frame_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "cgmii_consts.svh"

module cgmii_frame_gen import cgmii_pkg::*; (
	input  logic        i_clock,
	input  logic        i_reset,
	input  idle_count_t i_num_idle,
	input  data_count_t i_num_data,
	input  logic        i_force_error,  // One-cycle pulse
	input  logic        i_almost_full,
	output logic        o_wr_en,
	output cgmii_data_t o_wr_data,
	output cgmii_ctrl_t o_wr_ctrl
);

	localparam int ERR_W = $clog2(`CGMII_ERR_WORDS + 1);
	localparam logic [ERR_W-1:0] ERR_LAST = ERR_W'(`CGMII_ERR_WORDS - 1);

	gen_state_t       state;
	idle_count_t      idle_cnt;
	data_count_t      data_cnt;     // Start word at 0 and data words from 1
	logic [ERR_W-1:0] err_cnt;
	idle_count_t      num_idle_q;
	data_count_t      num_data_q;
	logic [7:0]       byte_cnt;     // First payload byte of the current data word
	cgmii_data_t      payload;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state      <= INIT;
			idle_cnt   <= '0;
			data_cnt   <= '0;
			err_cnt    <= '0;
			byte_cnt   <= '0;
			num_idle_q <= '0;
			num_data_q <= '0;
		end else if (i_force_error && state != TX_E) begin
			// Forced error wins over a stall
			state    <= TX_E;
			err_cnt  <= '0;
			data_cnt <= '0;
			idle_cnt <= '0;
		end else if (!i_almost_full) begin
			case (state)
				INIT: begin
					num_idle_q <= i_num_idle;        // Config only taken here
					num_data_q <= i_num_data;
					idle_cnt   <= '0;
					data_cnt   <= '0;
					state      <= TX_C;
				end
				TX_C: begin
					if (idle_cnt == num_idle_q) begin
						idle_cnt <= '0;
						state    <= TX_D;
					end else begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				TX_D: begin
					if (data_cnt == '0) begin
						byte_cnt <= '0;                  // Payload restarts every frame
					end else begin
						byte_cnt <= byte_cnt + 8'd8;
					end
					if (data_cnt == num_data_q) begin
						data_cnt <= '0;
						state    <= TX_T;
					end else begin
						data_cnt <= data_cnt + 1'b1;
					end
				end
				TX_T: begin
					state <= INIT;
				end
				TX_E: begin
					if (err_cnt == ERR_LAST) begin
						err_cnt  <= '0;
						idle_cnt <= '0;
						state    <= TX_C;
					end else begin
						err_cnt <= err_cnt + 1'b1;
					end
				end
				default: begin
					state <= INIT;
				end
			endcase
		end
	end

	// Lane i carries byte_cnt + i
	always_comb begin
		for (int i = 0; i < `CGMII_CTRL_W; i++) begin
			payload[8*i +: 8] = byte_cnt + 8'(i);
		end
	end

	always_comb begin
		o_wr_ctrl = '1;
		o_wr_data = {`CGMII_CTRL_W{`CGMII_IDLE_BYTE}};
		case (state)
			TX_D: begin
				if (data_cnt == '0) begin
					o_wr_ctrl = cgmii_ctrl_t'(1);                   // Lane 0 is control
					o_wr_data = cgmii_data_t'(`CGMII_START_BYTE);
				end else begin
					o_wr_ctrl = '0;
					o_wr_data = payload;
				end
			end
			TX_T: begin
				o_wr_data = {{(`CGMII_CTRL_W-1){`CGMII_IDLE_BYTE}}, `CGMII_TERM_BYTE};
			end
			TX_E: begin
				o_wr_data = {`CGMII_CTRL_W{`CGMII_ERR_BYTE}};
			end
			default: begin
				o_wr_ctrl = '1;                                  // Idle in INIT and TX_C
			end
		endcase
	end

	// INIT writes nothing and every other state writes one word per free cycle
	assign o_wr_en = (state != INIT) && !i_almost_full;

endmodule

`default_nettype wire

//--- cgmii_link_top.sv
`timescale 1ns/10ps
`default_nettype none

module cgmii_link_top import cgmii_pkg::*; (
	input  logic        i_clock,
	input  logic        i_reset,
	input  idle_count_t i_num_idle,
	input  data_count_t i_num_data,
	input  logic        i_force_error,
	input  logic        i_rx_enable,
	output logic        o_frame_strobe,
	output logic        o_frame_good,
	output data_count_t o_frame_len,
	output stat_count_t o_good_frames,
	output stat_count_t o_bad_frames,
	output stat_count_t o_error_words,
	output logic        o_overflow
);

	// Producer side
	logic        wr_en;
	cgmii_data_t wr_data;
	cgmii_ctrl_t wr_ctrl;
	logic        almost_full;

	// Consumer side
	logic        rd_en;
	cgmii_data_t rd_data;
	cgmii_ctrl_t rd_ctrl;
	logic        empty;

	cgmii_frame_gen cgmii_frame_gen_i (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_num_idle    (i_num_idle),
		.i_num_data    (i_num_data),
		.i_force_error (i_force_error),
		.i_almost_full (almost_full),
		.o_wr_en       (wr_en),
		.o_wr_data     (wr_data),
		.o_wr_ctrl     (wr_ctrl)
	);

	cgmii_word_fifo cgmii_word_fifo_i (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_wr_en       (wr_en),
		.i_wr_data     (wr_data),
		.i_wr_ctrl     (wr_ctrl),
		.i_rd_en       (rd_en),
		.o_rd_data     (rd_data),
		.o_rd_ctrl     (rd_ctrl),
		.o_empty       (empty),
		.o_almost_full (almost_full),
		.o_overflow    (o_overflow)
	);

	cgmii_frame_checker cgmii_frame_checker_i (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_rx_enable    (i_rx_enable),
		.i_empty        (empty),
		.i_rd_data      (rd_data),
		.i_rd_ctrl      (rd_ctrl),
		.o_rd_en        (rd_en),
		.o_frame_strobe (o_frame_strobe),
		.o_frame_good   (o_frame_good),
		.o_frame_len    (o_frame_len),
		.o_good_frames  (o_good_frames),
		.o_bad_frames   (o_bad_frames),
		.o_error_words  (o_error_words)
	);

endmodule

`default_nettype wire

//--- cgmii_pkg.sv
`default_nettype none

`include "cgmii_consts.svh"

package cgmii_pkg;

	typedef logic [`CGMII_DATA_W-1:0]    cgmii_data_t;    // Lane 0 in the low bits
	typedef logic [`CGMII_CTRL_W-1:0]    cgmii_ctrl_t;    // One control bit per lane
	typedef logic [`CGMII_IDLE_NBIT-1:0] idle_count_t;
	typedef logic [`CGMII_DATA_NBIT-1:0] data_count_t;    // Also frame length
	typedef logic [`CGMII_CNT_W-1:0]     stat_count_t;

	// Generator states
	typedef enum logic [2:0] {
		INIT,
		TX_C,
		TX_D,
		TX_T,
		TX_E
	} gen_state_t;

	// Checker parse states
	typedef enum logic {
		CHK_IDLE,
		CHK_FRAME
	} chk_state_t;

endpackage

`default_nettype wire

//--- cgmii_word_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "cgmii_consts.svh"

module cgmii_word_fifo import cgmii_pkg::*; (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_wr_en,
	input  cgmii_data_t i_wr_data,
	input  cgmii_ctrl_t i_wr_ctrl,
	input  logic        i_rd_en,
	output cgmii_data_t o_rd_data,
	output cgmii_ctrl_t o_rd_ctrl,
	output logic        o_empty,
	output logic        o_almost_full,
	output logic        o_overflow      // Sticky
);

	localparam int ADDR_W = $clog2(`CGMII_FIFO_DEPTH);
	localparam int CNT_W  = ADDR_W + 1;

	logic [`CGMII_CTRL_W+`CGMII_DATA_W-1:0] mem [`CGMII_FIFO_DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              full;
	logic              do_wr;
	logic              do_rd;

	assign full    = (count == CNT_W'(`CGMII_FIFO_DEPTH));
	assign o_empty = (count == '0);
	assign do_wr   = i_wr_en && !full;
	assign do_rd   = i_rd_en && !o_empty;

	always_ff @(posedge i_clock) begin
		if (do_wr) begin
			mem[wr_ptr] <= {i_wr_ctrl, i_wr_data};
		end
	end

	// Read data is valid the cycle after i_rd_en
	always_ff @(posedge i_clock) begin
		if (do_rd) begin
			{o_rd_ctrl, o_rd_data} <= mem[rd_ptr];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			o_almost_full <= 1'b0;
			o_overflow    <= 1'b0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;           // Power-of-two depth wraps
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			o_almost_full <= (count >= CNT_W'(`CGMII_FIFO_AFULL));
			if (i_wr_en && full) o_overflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cgmii_link -f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_cgmii_link +verilator+error+limit+1000)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

//--- tb.f
+incdir+.
cgmii_pkg.sv
cgmii_frame_gen.sv
cgmii_word_fifo.sv
cgmii_frame_checker.sv
cgmii_link_top.sv
tb_cgmii_properties.sv
tb_cgmii_link.sv

//--- tb_cgmii_link.sv
`timescale 1ns/10ps
`default_nettype none

`include "cgmii_consts.svh"

module tb_cgmii_link import cgmii_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 2;
	localparam int PH1_CYCLES   = 300;
	localparam int PH2_CYCLES   = 600;
	localparam int PH3_CYCLES   = 600;                                // Settle, pulses, drain
	localparam int PH4_RUN      = 300;
	localparam int PH4_CYCLES   = 2 * (PH4_RUN + RESET_CYCLES + 1);
	localparam int RUN_CYCLES   = RESET_CYCLES + PH1_CYCLES + PH2_CYCLES + PH3_CYCLES + PH4_CYCLES;
	localparam int PULSES       = 8;

	logic        i_clock;
	logic        i_reset;
	idle_count_t i_num_idle;
	data_count_t i_num_data;
	logic        i_force_error;
	logic        i_rx_enable;
	logic        o_frame_strobe;
	logic        o_frame_good;
	data_count_t o_frame_len;
	stat_count_t o_good_frames;
	stat_count_t o_bad_frames;
	stat_count_t o_error_words;
	logic        o_overflow;

	logic [31:0] rng;
	int          compare_count;
	int          error_count;
	int          pulse_count;
	int          assert_failures;
	stat_count_t good_start;
	stat_count_t bad_start;
	stat_count_t err_start;

	cgmii_link_top cgmii_link_top_i (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_num_idle     (i_num_idle),
		.i_num_data     (i_num_data),
		.i_force_error  (i_force_error),
		.i_rx_enable    (i_rx_enable),
		.o_frame_strobe (o_frame_strobe),
		.o_frame_good   (o_frame_good),
		.o_frame_len    (o_frame_len),
		.o_good_frames  (o_good_frames),
		.o_bad_frames   (o_bad_frames),
		.o_error_words  (o_error_words),
		.o_overflow     (o_overflow)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic step(input int n);
		repeat (n) @(posedge i_clock);
	endtask

	// Config may only change while reset is held
	task automatic apply_reset(input idle_count_t num_idle, input data_count_t num_data);
		@(posedge i_clock);
		i_reset     <= 1'b1;
		i_rx_enable <= 1'b0;
		i_num_idle  <= num_idle;
		i_num_data  <= num_data;
		step(RESET_CYCLES);
		i_reset <= 1'b0;
	endtask

	task automatic run_traffic(input int cycles, input bit random_rx);
		repeat (cycles) begin
			@(posedge i_clock);
			rng = xorshift32(rng);
			i_rx_enable <= random_rx ? rng[7] : 1'b1;
		end
	endtask

	task automatic pulse_force_error();
		@(posedge i_clock);
		i_force_error <= 1'b1;
		@(posedge i_clock);
		i_force_error <= 1'b0;
		pulse_count++;
	endtask

	task automatic wait_good_frames(input stat_count_t target);
		while (o_good_frames < target) @(posedge i_clock);
	endtask

	task automatic compare_value(input string name, input int got, input int exp);
		compare_count++;
		if (got != exp) begin
			error_count++;
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic confirm(input bit cond, input string what);
		compare_count++;
		if (!cond) begin
			error_count++;
			$display("ERROR at %0t: %s", $time, what);
		end
	endtask

	initial begin
		i_clock = 1'b0;
		forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
	end

	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD);
		$display("ERROR: run timed out after %0d cycles", 2 * RUN_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rng           = xorshift32(32'h0d7d4002);
		compare_count = 0;
		error_count   = 0;
		pulse_count   = 0;
		i_reset       = 1'b1;
		i_num_idle    = idle_count_t'(rng[4:0]);
		i_num_data    = data_count_t'(1 + rng[15:8] % 20);
		i_force_error = 1'b0;
		i_rx_enable   = 1'b0;
		step(RESET_CYCLES);
		i_reset <= 1'b0;

		good_start = o_good_frames;                                  // Steady reader
		run_traffic(PH1_CYCLES, 1'b0);
		confirm(o_good_frames > good_start, "no good frame counted in steady phase");

		good_start = o_good_frames;                                  // Random back-pressure
		run_traffic(PH2_CYCLES, 1'b1);
		confirm(o_good_frames > good_start, "no good frame counted under back-pressure");

		run_traffic(20, 1'b0);                                       // Empty the backlog first
		err_start   = o_error_words;
		bad_start   = o_bad_frames;
		pulse_count = 0;
		repeat (PULSES) begin
			pulse_force_error();
			rng = xorshift32(rng);
			run_traffic(10 + int'(rng[3:0]), 1'b0);
		end
		wait_good_frames(stat_count_t'(o_good_frames + 3));         // All bursts read by now
		compare_value("o_error_words", int'(o_error_words - err_start),
			`CGMII_ERR_WORDS * pulse_count);
		confirm(int'(o_bad_frames - bad_start) <= pulse_count,
			"more bad frames than forced errors");

		rng = xorshift32(rng);
		apply_reset(idle_count_t'(rng[4:0]), data_count_t'(rng[15:8] % 20));
		run_traffic(PH4_RUN, 1'b1);
		confirm(o_good_frames > 0, "no good frame counted with second configuration");
		rng = xorshift32(rng);
		apply_reset(idle_count_t'(rng[4:0]), '0);                   // Zero-length frames
		run_traffic(PH4_RUN, 1'b1);
		confirm(o_good_frames > 0, "no good zero-length frame counted");

		step(2);
		assert_failures = cgmii_link_top_i.tb_cgmii_properties_i.fail_count;
		$display("Summary: %0d compares, %0d compare errors, %0d assertion failures",
			compare_count, error_count, assert_failures);
		if (error_count == 0 && assert_failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_cgmii_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "cgmii_consts.svh"

module tb_cgmii_properties import cgmii_pkg::*; (
	input logic        i_clock,
	input logic        i_reset,
	input data_count_t i_num_data,
	input logic        i_force_error,
	input logic        i_frame_strobe,
	input logic        i_frame_good,
	input data_count_t i_frame_len,
	input stat_count_t i_good_frames,
	input stat_count_t i_bad_frames,
	input stat_count_t i_error_words,
	input logic        i_overflow
);

	int                    fail_count = 0;   // Read by the testbench at the end
	logic                  error_seen;       // A forced error since the last reset
	logic [`CGMII_CNT_W:0] frame_total;

	assign frame_total = {1'b0, i_good_frames} + {1'b0, i_bad_frames};

	always_ff @(posedge i_clock) begin
		if (i_reset) error_seen <= 1'b0;
		else if (i_force_error) error_seen <= 1'b1;
	end

	reset_clears: assert property (@(posedge i_clock) i_reset |=> (!i_frame_strobe &&
		i_good_frames == '0 && i_bad_frames == '0 && i_error_words == '0))
	else begin
		$error("Strobe or counters not cleared by reset");
		fail_count++;
	end

	good_len: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_frame_strobe && i_frame_good) |-> (i_frame_len == i_num_data))
	else begin
		$error("Good frame length %0d differs from configured %0d", i_frame_len, i_num_data);
		fail_count++;
	end

	// Without forced errors every frame has to arrive intact
	clean_frames: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_frame_strobe && !error_seen) |-> i_frame_good)
	else begin
		$error("Bad frame reported with no forced error");
		fail_count++;
	end

	no_overflow: assert property (@(posedge i_clock) disable iff (i_reset) !i_overflow)
	else begin
		$error("FIFO overflow flag set");
		fail_count++;
	end

	total_rises: assert property (@(posedge i_clock) disable iff (i_reset)
		frame_total >= $past(frame_total))
	else begin
		$error("Good plus bad frame count went down");
		fail_count++;
	end

endmodule

bind cgmii_link_top tb_cgmii_properties tb_cgmii_properties_i (
	.i_clock        (i_clock),
	.i_reset        (i_reset),
	.i_num_data     (i_num_data),
	.i_force_error  (i_force_error),
	.i_frame_strobe (o_frame_strobe),
	.i_frame_good   (o_frame_good),
	.i_frame_len    (o_frame_len),
	.i_good_frames  (o_good_frames),
	.i_bad_frames   (o_bad_frames),
	.i_error_words  (o_error_words),
	.i_overflow     (o_overflow)
);

`default_nettype wire
